//--- shell_defs.svh
/*
 * Accelerator shell constants
 * Core reset length, address width and APB register map
 */

`ifndef SHELL_DEFS_SVH
`define SHELL_DEFS_SVH

// Cycles the core is held in reset after a go
`define SHELL_RESET_DELAY 8

`define SHELL_ADDR_W 32

////////////////////
// APB register offsets, decoded on paddr[7:0]
`define SHELL_REG_BASE   8'h50  // Memory base added to every request
`define SHELL_REG_CTRL   8'h54  // Bit 0 is go
`define SHELL_REG_STATUS 8'h58  // Read only, bit 0 is busy
`define SHELL_REG_SRC    8'h5C
`define SHELL_REG_DST    8'h60
`define SHELL_REG_LEN    8'h64  // Length in 32-bit words

`endif

//--- shell_pkg.sv
/*
 * Accelerator shell types
 * Copy engine FSM states and memory request opcodes
 */

package shell_pkg;

   ////////////////////
   // Copy engine FSM
   typedef enum logic [1:0] {
      COPY_IDLE  = 2'd0,
      COPY_READ  = 2'd1,  // Read request for the current word
      COPY_WAIT  = 2'd2,  // Waiting on the read response
      COPY_WRITE = 2'd3   // Write of the captured word
   } copy_state_e;

   ////////////////////
   // Memory request opcode
   typedef enum logic {
      MEM_READ  = 1'b0,
      MEM_WRITE = 1'b1
   } mem_op_e;

endpackage

//--- apb_config_regs.sv
/*
 * APB configuration slave
 * Holds base, source, destination and length, raises go and reports busy
 */

`include "shell_defs.svh"

module apb_config_regs (
   input  logic        clk,
   input  logic        vx_reset_started,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [31:0] paddr,
   input  logic [31:0] pwdata,
   input  logic        busy,
   input  logic        started,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        go,
   output logic [31:0] base,
   output logic [31:0] src,
   output logic [31:0] dst,
   output logic [31:0] len
);

   logic       apb_write;
   logic       apb_read;
   logic [7:0] reg_addr;
   logic       go_bit;     // CTRL bit 0, cleared once the core starts

   assign reg_addr  = paddr[7:0];
   assign apb_write = psel & penable & pwrite;  // Access phase
   assign apb_read  = psel & ~pwrite;           // Captured from setup phase
   assign pready    = 1'b1;

   // Go only accepted while the whole shell is quiet
   assign go = apb_write & (reg_addr == `SHELL_REG_CTRL) & pwdata[0] & ~busy;

   ////////////////////
   // Register writes
   always_ff @(posedge clk) begin
      if (vx_reset_started) begin
         base <= 32'd0;
         src  <= 32'd0;
         dst  <= 32'd0;
         len  <= 32'd0;
      end else if (apb_write) begin
         case (reg_addr)
            `SHELL_REG_BASE: base <= pwdata;
            `SHELL_REG_SRC:  src  <= pwdata;
            `SHELL_REG_DST:  dst  <= pwdata;
            `SHELL_REG_LEN:  len  <= pwdata;
            default: ;  // Unknown offsets and CTRL handled elsewhere
         endcase
      end
   end

   // Go bit stays visible through the core reset phase
   always_ff @(posedge clk) begin
      if (vx_reset_started) begin
         go_bit <= 1'b0;
      end else if (go) begin
         go_bit <= 1'b1;
      end else if (started) begin
         go_bit <= 1'b0;
      end
   end

   ////////////////////
   // Registered read data
   always_ff @(posedge clk) begin
      if (vx_reset_started) begin
         prdata <= 32'd0;
      end else if (apb_read) begin
         case (reg_addr)
            `SHELL_REG_BASE:   prdata <= base;
            `SHELL_REG_CTRL:   prdata <= {31'd0, go_bit};
            `SHELL_REG_STATUS: prdata <= {31'd0, busy};
            `SHELL_REG_SRC:    prdata <= src;
            `SHELL_REG_DST:    prdata <= dst;
            `SHELL_REG_LEN:    prdata <= len;
            default:           prdata <= 32'd0;
         endcase
      end
   end

endmodule

//--- core_reset_seq.sv
/*
 * Core reset sequencer
 * Holds the core in reset for a fixed count after go, then strobes start
 */

`include "shell_defs.svh"

module core_reset_seq (
   input  logic clk,
   input  logic vx_reset_started,
   input  logic go,
   output logic core_reset,
   output logic start,
   output logic active
);

   localparam int CTR_W = $clog2(`SHELL_RESET_DELAY + 1);

   logic [CTR_W-1:0] rst_ctr;  // Cycles left in the core reset phase

   always_ff @(posedge clk) begin
      if (vx_reset_started) begin
         rst_ctr    <= '0;
         core_reset <= 1'b0;
         start      <= 1'b0;
      end else begin
         start <= 1'b0;  // Single cycle strobe
         if (go && !active) begin
            core_reset <= 1'b1;
            rst_ctr    <= CTR_W'(`SHELL_RESET_DELAY - 1);
         end else if (core_reset) begin
            if (rst_ctr == '0) begin
               // Reset released, core may run next
               core_reset <= 1'b0;
               start      <= 1'b1;
            end else begin
               rst_ctr <= rst_ctr - CTR_W'(1);
            end
         end
      end
   end

   // Covers reset phase and the start cycle
   assign active = core_reset | start;

endmodule

//--- copy_engine.sv
/*
 * Memory copy engine
 * Reads each source word and writes it back at the destination offset
 */

`include "shell_defs.svh"

module copy_engine (
   input  logic                     clk,
   input  logic                     vx_reset_started,
   input  logic                     core_reset,
   input  logic                     start,
   input  logic [`SHELL_ADDR_W-1:0] src,
   input  logic [`SHELL_ADDR_W-1:0] dst,
   input  logic [31:0]              len,
   input  logic                     mem_rsp_valid,
   input  logic [31:0]              mem_rsp_data,
   output logic                     req_valid,
   output shell_pkg::mem_op_e       req_op,
   output logic [`SHELL_ADDR_W-1:0] req_addr,
   output logic [31:0]              req_wdata,
   output logic                     engine_busy
);

   shell_pkg::copy_state_e state;
   shell_pkg::copy_state_e state_nxt;

   logic [31:0]              word_idx;
   logic [`SHELL_ADDR_W-1:0] src_q;
   logic [`SHELL_ADDR_W-1:0] dst_q;
   logic [31:0]              len_q;
   logic [31:0]              rdata_q;    // Word in transit
   logic [`SHELL_ADDR_W-1:0] word_off;   // Byte offset of current word
   logic                     no_words;
   logic                     last_word;

   assign word_off  = {word_idx[`SHELL_ADDR_W-3:0], 2'b00};
   assign no_words  = (word_idx == len_q);
   assign last_word = ((word_idx + 32'd1) == len_q);

   ////////////////////
   // Next state
   always_comb begin
      state_nxt = state;
      case (state)
         shell_pkg::COPY_IDLE: begin
            if (start) state_nxt = shell_pkg::COPY_READ;
         end
         shell_pkg::COPY_READ: begin
            // Zero length drops straight back
            state_nxt = no_words ? shell_pkg::COPY_IDLE : shell_pkg::COPY_WAIT;
         end
         shell_pkg::COPY_WAIT: begin
            if (mem_rsp_valid) state_nxt = shell_pkg::COPY_WRITE;
         end
         shell_pkg::COPY_WRITE: begin
            state_nxt = last_word ? shell_pkg::COPY_IDLE : shell_pkg::COPY_READ;
         end
         default: state_nxt = shell_pkg::COPY_IDLE;
      endcase
   end

   // Control state, core_reset holds the engine idle
   always_ff @(posedge clk) begin
      if (vx_reset_started || core_reset) begin
         state    <= shell_pkg::COPY_IDLE;
         word_idx <= 32'd0;
      end else begin
         state <= state_nxt;
         if (state == shell_pkg::COPY_IDLE && start) begin
            word_idx <= 32'd0;
         end else if (state == shell_pkg::COPY_WRITE) begin
            word_idx <= word_idx + 32'd1;
         end
      end
   end

   ////////////////////
   // Job parameters and read data
   always_ff @(posedge clk) begin
      if (state == shell_pkg::COPY_IDLE && start) begin
         src_q <= src;
         dst_q <= dst;
         len_q <= len;
      end
      if (state == shell_pkg::COPY_WAIT && mem_rsp_valid) begin
         rdata_q <= mem_rsp_data;
      end
   end

   // Request outputs straight from state
   always_comb begin
      req_valid = 1'b0;
      req_op    = shell_pkg::MEM_READ;
      req_addr  = src_q + word_off;
      if (state == shell_pkg::COPY_READ) begin
         req_valid = !no_words;
      end else if (state == shell_pkg::COPY_WRITE) begin
         req_valid = 1'b1;
         req_op    = shell_pkg::MEM_WRITE;
         req_addr  = dst_q + word_off;
      end
   end

   assign req_wdata   = rdata_q;
   assign engine_busy = (state != shell_pkg::COPY_IDLE);

endmodule

//--- addr_rebase_stage.sv
/*
 * Address rebase stage
 * Registers each request and adds the memory base to its address
 */

`include "shell_defs.svh"

module addr_rebase_stage (
   input  logic                     clk,
   input  logic                     vx_reset_started,
   input  logic [`SHELL_ADDR_W-1:0] base,
   input  logic                     req_valid,
   input  shell_pkg::mem_op_e       req_op,
   input  logic [`SHELL_ADDR_W-1:0] req_addr,
   input  logic [31:0]              req_wdata,
   output logic                     mem_valid,
   output shell_pkg::mem_op_e       mem_op,
   output logic [`SHELL_ADDR_W-1:0] mem_addr,
   output logic [31:0]              mem_wdata
);

   ////////////////////
   // Valid strobe, follows every request
   always_ff @(posedge clk) begin
      if (vx_reset_started) begin
         mem_valid <= 1'b0;
      end else begin
         mem_valid <= req_valid;
      end
   end

   // Payload, loaded on each request so back to back strobes both pass
   always_ff @(posedge clk) begin
      if (req_valid) begin
         mem_op    <= req_op;
         mem_addr  <= req_addr + base;  // Offset into the reserved region
         mem_wdata <= req_wdata;
      end
   end

endmodule

//--- accel_shell_top.sv
/*
 * Accelerator shell top level
 * APB configuration, core reset sequencing, copy core and address rebase
 */

`include "shell_defs.svh"

module accel_shell_top (
   input  logic                     clk,
   input  logic                     vx_reset_started,
   input  logic                     psel,
   input  logic                     penable,
   input  logic                     pwrite,
   input  logic [31:0]              paddr,
   input  logic [31:0]              pwdata,
   input  logic                     mem_rsp_valid,
   input  logic [31:0]              mem_rsp_data,
   output logic [31:0]              prdata,
   output logic                     pready,
   output logic                     mem_valid,
   output shell_pkg::mem_op_e       mem_op,
   output logic [`SHELL_ADDR_W-1:0] mem_addr,
   output logic [31:0]              mem_wdata,
   output logic                     busy
);

   logic                     go;
   logic [31:0]              base;
   logic [31:0]              src;
   logic [31:0]              dst;
   logic [31:0]              len;
   logic                     core_reset;
   logic                     start;
   logic                     seq_active;
   logic                     engine_busy;
   logic                     req_valid;
   shell_pkg::mem_op_e       req_op;
   logic [`SHELL_ADDR_W-1:0] req_addr;
   logic [31:0]              req_wdata;

   // Anything still moving counts as busy
   assign busy = seq_active | engine_busy | mem_valid;

   ////////////////////
   // Stage chain
   apb_config_regs u_regs (
      .clk              (clk),
      .vx_reset_started (vx_reset_started),
      .psel             (psel),
      .penable          (penable),
      .pwrite           (pwrite),
      .paddr            (paddr),
      .pwdata           (pwdata),
      .busy             (busy),
      .started          (start),
      .prdata           (prdata),
      .pready           (pready),
      .go               (go),
      .base             (base),
      .src              (src),
      .dst              (dst),
      .len              (len)
   );

   core_reset_seq u_seq (
      .clk              (clk),
      .vx_reset_started (vx_reset_started),
      .go               (go),
      .core_reset       (core_reset),
      .start            (start),
      .active           (seq_active)
   );

   copy_engine u_engine (
      .clk              (clk),
      .vx_reset_started (vx_reset_started),
      .core_reset       (core_reset),
      .start            (start),
      .src              (src),
      .dst              (dst),
      .len              (len),
      .mem_rsp_valid    (mem_rsp_valid),
      .mem_rsp_data     (mem_rsp_data),
      .req_valid        (req_valid),
      .req_op           (req_op),
      .req_addr         (req_addr),
      .req_wdata        (req_wdata),
      .engine_busy      (engine_busy)
   );

   addr_rebase_stage u_rebase (
      .clk              (clk),
      .vx_reset_started (vx_reset_started),
      .base             (base),
      .req_valid        (req_valid),
      .req_op           (req_op),
      .req_addr         (req_addr),
      .req_wdata        (req_wdata),
      .mem_valid        (mem_valid),
      .mem_op           (mem_op),
      .mem_addr         (mem_addr),
      .mem_wdata        (mem_wdata)
   );

endmodule

//--- tb_accel_shell_assertions.sv
/*
 * Accelerator shell assertions
 * Memory port reset, read response and busy rules
 */

module tb_accel_shell_assertions (
   input logic               clk,
   input logic               vx_reset_started,
   input logic               mem_valid,
   input shell_pkg::mem_op_e mem_op,
   input logic               mem_rsp_valid,
   input logic               busy,
   input logic               seq_active,
   input logic               engine_busy,
   input logic               go
);
   timeunit 1ns;
   timeprecision 100ps;

   logic rd_outstanding;  // Read issued, response not yet seen

   always_ff @(posedge clk) begin
      if (vx_reset_started) begin
         rd_outstanding <= 1'b0;
      end else if (mem_valid && mem_op == shell_pkg::MEM_READ) begin
         rd_outstanding <= 1'b1;
      end else if (mem_rsp_valid) begin
         rd_outstanding <= 1'b0;
      end
   end

   ////////////////////
   // Memory port stays quiet through reset
   mem_quiet_in_reset: assert property (@(posedge clk) vx_reset_started |=> !mem_valid)
      else $error("mem_valid high during reset");

   rsp_needs_read: assert property (@(posedge clk) disable iff (vx_reset_started)
      mem_rsp_valid |-> rd_outstanding)
      else $error("read response with no read outstanding");

   // Last request drains one cycle after the engine goes idle
   idle_not_busy: assert property (@(posedge clk) disable iff (vx_reset_started)
      (!seq_active && !engine_busy && !go) |=> !busy)
      else $error("busy high with the shell idle");

endmodule

bind accel_shell_top tb_accel_shell_assertions u_assertions (
   .clk              (clk),
   .vx_reset_started (vx_reset_started),
   .mem_valid        (mem_valid),
   .mem_op           (mem_op),
   .mem_rsp_valid    (mem_rsp_valid),
   .busy             (busy),
   .seq_active       (seq_active),
   .engine_busy      (engine_busy),
   .go               (go)
);

//--- tb_accel_shell.sv
/*
 * Accelerator shell testbench
 * APB driver, memory model with random read latency and directed copy tests
 */

`include "shell_defs.svh"

module tb_accel_shell;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int IDLE_TIMEOUT = 400;

   logic               clk = 1'b0;
   logic               vx_reset_started = 1'b1;
   logic               psel = 1'b0;
   logic               penable = 1'b0;
   logic               pwrite = 1'b0;
   logic [31:0]        paddr = 32'd0;
   logic [31:0]        pwdata = 32'd0;
   logic               mem_rsp_valid = 1'b0;
   logic [31:0]        mem_rsp_data = 32'd0;
   logic [31:0]        prdata;
   logic               pready;
   logic               mem_valid;
   shell_pkg::mem_op_e mem_op;
   logic [31:0]        mem_addr;
   logic [31:0]        mem_wdata;
   logic               busy;

   logic [31:0]        lcg_state = 32'h88b;
   logic [31:0]        mem_model [logic [31:0]];  // Byte address to word
   logic [31:0]        src_words [$];             // Expected copy data
   shell_pkg::mem_op_e obs_op [$];                // Requests seen on the memory port
   logic [31:0]        obs_addr [$];
   int                 obs_cycle [$];
   int                 cycle_cnt = 0;
   int                 value_errors = 0;
   int                 other_errors = 0;
   logic [31:0]        rd_data;
   int                 rd_delay = -1;             // Cycles to the read response

   accel_shell_top UUT (.*);

   always #2 clk = ~clk;

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Unwritten words read back a pattern of the whole address
   function automatic logic [31:0] mem_fetch(input logic [31:0] addr);
      if (mem_model.exists(addr)) return mem_model[addr];
      return {addr[15:0], addr[31:16]} ^ 32'hc3a5_0f96;
   endfunction

   ////////////////////
   // Memory model, one read in flight
   always @(posedge clk) begin
      mem_rsp_valid <= 1'b0;
      if (!vx_reset_started && mem_valid) begin
         obs_op.push_back(mem_op);
         obs_addr.push_back(mem_addr);
         obs_cycle.push_back(cycle_cnt - 1);  // Edge at which mem_valid rose
         if (mem_op == shell_pkg::MEM_WRITE) begin
            mem_model[mem_addr] = mem_wdata;
         end else begin
            rd_data  = mem_fetch(mem_addr);
            rd_delay = int'((next_rand() >> 16) % 32'd4);  // 1 to 4 cycles
         end
      end
      if (rd_delay == 0) begin
         mem_rsp_valid <= 1'b1;
         mem_rsp_data  <= rd_data;
      end
      if (rd_delay >= 0) rd_delay--;
   end

   ////////////////////
   // Compare tasks
   task automatic check_word(input string test, input logic [31:0] exp,
                             input logic [31:0] act);
      if (act !== exp) begin
         $display("ERROR %s: expected %h, actual %h", test, exp, act);
         value_errors++;
      end
   endtask

   task automatic check_op(input string test, input shell_pkg::mem_op_e exp,
                           input shell_pkg::mem_op_e act);
      if (act !== exp) begin
         $display("ERROR %s: expected %s, actual %s", test, exp.name(), act.name());
         value_errors++;
      end
   endtask

   ////////////////////
   // APB driver
   task automatic apb_write(input logic [7:0] offset, input logic [31:0] data);
      @(posedge clk);
      psel    <= 1'b1;
      pwrite  <= 1'b1;
      paddr   <= {24'd0, offset};
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);  // Write lands on this edge
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] offset, output logic [31:0] data);
      @(posedge clk);
      psel    <= 1'b1;
      pwrite  <= 1'b0;
      paddr   <= {24'd0, offset};
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);  // prdata registered from the setup phase
      data = prdata;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic wait_idle(input string test);
      int cycles;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (busy !== 1'b0 && cycles < IDLE_TIMEOUT);
      if (busy !== 1'b0) begin
         $display("%s: shell still busy after %0d cycles", test, IDLE_TIMEOUT);
         other_errors++;
      end
   endtask

   // Seeds source words, programs the job and writes go
   task automatic start_copy(input logic [31:0] base, input logic [31:0] src,
                             input logic [31:0] dst, input int n);
      src_words.delete();
      for (int i = 0; i < n; i++) begin
         src_words.push_back(next_rand());
         mem_model[base + src + 32'(4 * i)] = src_words[i];
      end
      apb_write(`SHELL_REG_BASE, base);
      apb_write(`SHELL_REG_SRC, src);
      apb_write(`SHELL_REG_DST, dst);
      apb_write(`SHELL_REG_LEN, 32'(n));
      obs_op.delete();
      obs_addr.delete();
      obs_cycle.delete();
      apb_write(`SHELL_REG_CTRL, 32'd1);
   endtask

   task automatic check_copy(input string test, input logic [31:0] base,
                             input logic [31:0] src, input logic [31:0] dst, input int n);
      logic [31:0] wr_addr;
      check_word({test, " request count"}, 32'(2 * n), 32'(obs_op.size()));
      for (int i = 0; i < n; i++) begin
         wr_addr = base + dst + 32'(4 * i);
         if (obs_op.size() > 2 * i + 1) begin  // Read then write per word
            check_op({test, " read op"}, shell_pkg::MEM_READ, obs_op[2 * i]);
            check_word({test, " read addr"}, base + src + 32'(4 * i), obs_addr[2 * i]);
            check_op({test, " write op"}, shell_pkg::MEM_WRITE, obs_op[2 * i + 1]);
            check_word({test, " write addr"}, wr_addr, obs_addr[2 * i + 1]);
         end
         check_word({test, " dest memory"}, src_words[i], mem_fetch(wr_addr));
      end
   endtask

   ////////////////////
   // Directed tests
   task automatic test_register_readback();
      logic [7:0]  offs [5];
      logic [31:0] vals [5];
      logic [31:0] rdata;
      offs = '{`SHELL_REG_BASE, `SHELL_REG_SRC, `SHELL_REG_DST, `SHELL_REG_LEN, 8'h6c};
      vals = '{32'h1234_5670, 32'h0000_0abc, 32'h0000_0def, 32'd77, 32'hffff_ffff};
      foreach (offs[i]) apb_write(offs[i], vals[i]);
      vals[4] = 32'd0;  // Unmapped offset
      foreach (offs[i]) begin
         apb_read(offs[i], rdata);
         check_word($sformatf("readback %h", offs[i]), vals[i], rdata);
      end
      apb_read(`SHELL_REG_STATUS, rdata);
      check_word("readback status", 32'd0, rdata);
      check_word("readback pready", 32'd1, {31'd0, pready});
   endtask

   task automatic test_reset_sequencing();
      logic [31:0] rdata;
      int          go_cycle;
      start_copy(32'h0, 32'h200, 32'h300, 2);
      go_cycle = cycle_cnt;
      @(negedge clk);
      check_word("reset_seq busy", 32'd1, {31'd0, busy});
      apb_read(`SHELL_REG_CTRL, rdata);
      check_word("reset_seq go bit", 32'd1, rdata);  // Core still in reset
      wait_idle("reset_seq");
      if (obs_cycle.size() > 0 && obs_cycle[0] - go_cycle <= `SHELL_RESET_DELAY) begin
         $display("reset_seq: memory request %0d cycles after go, during core reset",
                  obs_cycle[0] - go_cycle);
         other_errors++;
      end
      apb_read(`SHELL_REG_CTRL, rdata);
      check_word("reset_seq go bit cleared", 32'd0, rdata);
      check_copy("reset_seq", 32'h0, 32'h200, 32'h300, 2);
   endtask

   task automatic test_copy_rebase();
      start_copy(32'h0001_0000, 32'h100, 32'h400, 6);
      wait_idle("copy_rebase");
      check_copy("copy_rebase", 32'h0001_0000, 32'h100, 32'h400, 6);
   endtask

   task automatic test_zero_length();
      logic [31:0] rdata;
      start_copy(32'h0004_0000, 32'h0, 32'h100, 0);
      wait_idle("zero_len");
      check_word("zero_len requests", 32'd0, 32'(obs_op.size()));
      apb_read(`SHELL_REG_STATUS, rdata);
      check_word("zero_len status", 32'd0, rdata);
   endtask

   task automatic test_back_to_back();
      int cycles;
      start_copy(32'h0002_0000, 32'h0, 32'h80, 4);
      cycles = 0;
      while (obs_op.size() == 0 && cycles < IDLE_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (obs_op.size() == 0) begin
         $display("b2b job a: no memory request within %0d cycles", IDLE_TIMEOUT);
         other_errors++;
      end
      apb_write(`SHELL_REG_CTRL, 32'd1);  // Second go while job a copies
      wait_idle("b2b job a");
      check_copy("b2b job a", 32'h0002_0000, 32'h0, 32'h80, 4);
      start_copy(32'h0003_0000, 32'h40, 32'hc0, 5);
      wait_idle("b2b job b");
      check_copy("b2b job b", 32'h0003_0000, 32'h40, 32'hc0, 5);
   endtask

   initial begin
      repeat (4) @(posedge clk);
      vx_reset_started <= 1'b0;
      test_register_readback();
      test_reset_sequencing();
      test_copy_rebase();
      test_zero_length();
      test_back_to_back();
      repeat (4) @(posedge clk);
      $display("Done: %0d value errors, %0d other errors", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- all.f
+incdir+.
shell_pkg.sv
apb_config_regs.sv
core_reset_seq.sv
copy_engine.sv
addr_rebase_stage.sv
accel_shell_top.sv
tb_accel_shell_assertions.sv
tb_accel_shell.sv

//--- Bender.yml
package:
  name: accel_shell

export_include_dirs:
  - .

sources:
  - shell_pkg.sv
  - apb_config_regs.sv
  - core_reset_seq.sv
  - copy_engine.sv
  - addr_rebase_stage.sv
  - accel_shell_top.sv
  - target: test
    files:
      - tb_accel_shell_assertions.sv
      - tb_accel_shell.sv
